//--- upCore.f
src/isaPkg.sv
src/memMapPkg.sv
src/upMemory.sv
src/progCounter.sv
src/controlFsm.sv
src/dataPath.sv
src/upCore.sv
sim/upChecker.sv
sim/upCoreTb.sv

//--- Bender.yml
package:
  name: upcore

sources:
  - src/isaPkg.sv
  - src/memMapPkg.sv
  - src/upMemory.sv
  - src/progCounter.sv
  - src/controlFsm.sv
  - src/dataPath.sv
  - src/upCore.sv
  - target: simulation
    files:
      - sim/upChecker.sv
      - sim/upCoreTb.sv

//--- sim/upCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module upCoreTb;
	import isaPkg::*;
	import memMapPkg::*;

	localparam int clkPeriod  = 40;
	localparam int numRuns    = 6;
	localparam int maxInstr   = 200;
	localparam int modelLimit = 1000;

	logic                 clk;
	logic                 nRst;
	logic [dataWidth-1:0] inData;
	logic [dataWidth-1:0] outData;
	logic                 outStrobe;
	logic                 halted;
	logic [dataWidth-1:0] testByte;

	int                   seed = 32'h16dce939;
	int                   checkCount;
	int                   checkErrors;
	int                   modelErrors;
	logic [dataWidth-1:0] expOut [256];
	int                   expOutCount;
	int                   expCycles;
	logic [dataWidth-1:0] expWatch;

	always #(clkPeriod / 2) clk = ~clk;

	upCore upCore_inst (
		.clk       (clk),
		.nRst      (nRst),
		.inData    (inData),
		.outData   (outData),
		.outStrobe (outStrobe),
		.halted    (halted),
		.testByte  (testByte)
	);

	upChecker upChecker_inst (
		.clk         (clk),
		.nRst        (nRst),
		.outData     (outData),
		.outStrobe   (outStrobe),
		.halted      (halted),
		.testByte    (testByte),
		.checkCount  (checkCount),
		.errorCount  (checkErrors)
	);

	// Runs the reset image as an ISA interpreter, returns the instruction count
	function automatic int runModel(input logic [7:0] inByte);
		logic [7:0] mem [256];
		logic [7:0] acc;
		logic [7:0] op;
		logic [7:0] opnd;
		logic [7:0] pc;
		logic [8:0] wide;
		logic       zf;
		logic       cf;
		logic       done;
		logic       accWritten;
		int         count;
		for (int i = 0; i < 256; i++) begin
			if (i < progLength) begin
				mem[i] = resetImage[i];
			end else begin
				mem[i] = 8'h00;
			end
		end
		acc = 8'h00;
		pc = 8'h00;
		zf = 1'b0;
		cf = 1'b0;
		done = 1'b0;
		count = 0;
		expOutCount = 0;
		expCycles = 0;
		while (!done && count < modelLimit) begin
			op = mem[pc];
			pc = pc + 8'd1;
			opnd = 8'h00;
			expCycles += 2; // Fetch and execute
			if (op[7:4] >= 4'h1 && op[7:4] <= 4'h4) begin
				opnd = mem[pc];
				pc = pc + 8'd1;
				expCycles += 1;
			end
			count++;
			accWritten = 1'b1;
			case (op)
				LDA: acc = mem[opnd];
				LDI: acc = opnd;
				IN:  acc = inByte;
				ADD: begin
					wide = {1'b0, acc} + {1'b0, mem[opnd]};
					acc = wide[7:0];
					cf = wide[8];
				end
				SUB: begin
					wide = {1'b0, acc} - {1'b0, mem[opnd]};
					acc = wide[7:0];
					cf = wide[8]; // Borrow
				end
				AND: begin
					acc = acc & mem[opnd];
					cf = 1'b0;
				end
				OR: begin
					acc = acc | mem[opnd];
					cf = 1'b0;
				end
				XOR: begin
					acc = acc ^ mem[opnd];
					cf = 1'b0;
				end
				default: accWritten = 1'b0;
			endcase
			case (op)
				STA: mem[opnd] = acc;
				JMP: pc = opnd;
				JZ:  pc = zf ? opnd : pc;
				JC:  pc = cf ? opnd : pc;
				OUT: begin
					expOut[expOutCount] = acc;
					expOutCount++;
				end
				NOP, LDA, LDI, IN, ADD, SUB, AND, OR, XOR: begin
				end
				default: done = 1'b1; // HLT or an illegal byte
			endcase
			if (accWritten) begin
				zf = (acc == 8'h00);
			end
		end
		expWatch = mem[watchAddr];
		if (!done || count > maxInstr) begin
			$display("Reference model ran %0d instructions without a timely HLT", count);
			modelErrors++;
		end
		return count;
	endfunction

	initial begin
		int             instrCount;
		logic [31:0]    randWord;
		logic [7:0]     inByte;
		logic [7:0]     resetWatch;
		clk = 1'b0;
		nRst = 1'b1;
		inData = '0;
		modelErrors = 0;
		resetWatch = 8'h00; // Zero unless the program image reaches the watch byte
		for (int i = 0; i < progLength; i++) begin
			if (i == watchAddr) begin
				resetWatch = resetImage[i];
			end
		end
		for (int run = 0; run < numRuns; run++) begin
			randWord = $random(seed);
			inByte = randWord[7:0];
			@(posedge clk);
			nRst <= 1'b0;
			inData <= inByte; // Held for the whole run
			@(posedge clk);
			instrCount = runModel(inByte);
			upChecker_inst.loadExpectation(resetWatch, expWatch, expCycles);
			for (int i = 0; i < expOutCount; i++) begin
				upChecker_inst.expectOut(expOut[i]);
			end
			$display("Run %0d: inData %02h, %0d instructions, %0d OUT bytes",
				run, inByte, instrCount, expOutCount);
			repeat (3) @(posedge clk);
			nRst <= 1'b1;
			while (!halted) begin
				@(posedge clk);
			end
			repeat (3) @(posedge clk); // Halt must hold with no strobes
		end
		$display("Runs: %0d, checks: %0d, errors: %0d", numRuns, checkCount,
			checkErrors + modelErrors);
		if (checkErrors + modelErrors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	initial begin
		#(numRuns * (maxInstr * 3 + 4 + 10) * clkPeriod);
		$display("Timeout: the core did not halt within the cycle budget of all runs");
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/upChecker.sv
`timescale 1ns/1ps
`default_nettype none

module upChecker (
	input  logic                         clk,
	input  logic                         nRst,
	input  logic [isaPkg::dataWidth-1:0] outData,
	input  logic                         outStrobe,
	input  logic                         halted,
	input  logic [isaPkg::dataWidth-1:0] testByte,
	output int                           checkCount,
	output int                           errorCount
);
	import isaPkg::*;

	logic                 armed = 1'b0;
	int                   cycleIdx;
	int                   haltCycle;
	logic [dataWidth-1:0] resetWatch;
	logic [dataWidth-1:0] finalWatch;
	logic [dataWidth-1:0] outQueue [$];

	initial begin
		checkCount = 0;
		errorCount = 0;
	end

	task automatic loadExpectation(input logic [7:0] atReset, input logic [7:0] atHalt,
		input int cycles);
		resetWatch = atReset;
		finalWatch = atHalt;
		haltCycle = cycles;
		outQueue.delete();
		armed = 1'b1;
	endtask

	task automatic expectOut(input logic [7:0] value);
		outQueue.push_back(value);
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("ERROR at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
		end
	endtask

	// Outputs settle after the rising edge, so sample on the falling one
	always @(negedge clk) begin
		if (!nRst) begin
			cycleIdx = 0;
		end else if (armed) begin
			if (cycleIdx == 0) begin
				checkValue("testByte", resetWatch, testByte);
			end
			if (cycleIdx < 2) begin
				checkValue("outStrobe", 0, outStrobe); // First instruction still running
			end
			checkValue("halted", (cycleIdx >= haltCycle) ? 1 : 0, halted);
			if (cycleIdx == haltCycle) begin
				checkValue("testByte", finalWatch, testByte);
				if (outQueue.size() != 0) begin
					errorCount++;
					$display("Core halted at %0t with %0d expected OUT bytes never seen",
						$time, outQueue.size());
				end
			end
			if (outStrobe) begin
				if (halted) begin
					errorCount++;
					$display("OUT strobe at %0t while the core is halted", $time);
				end else if (outQueue.size() == 0) begin
					errorCount++;
					$display("Unexpected extra OUT strobe at %0t", $time);
				end else begin
					checkValue("outData", outQueue[0], outData);
					void'(outQueue.pop_front());
				end
			end
			cycleIdx++;
		end
	end

endmodule

`default_nettype wire

//--- src/upCore.sv
`timescale 1ns/1ps
`default_nettype none

module upCore (
	input  logic                         clk,
	input  logic                         nRst,
	input  logic [isaPkg::dataWidth-1:0] inData,
	output logic [isaPkg::dataWidth-1:0] outData,
	output logic                         outStrobe,
	output logic                         halted,
	output logic [isaPkg::dataWidth-1:0] testByte
);
	import isaPkg::*;
	import memMapPkg::*;

	opcodeT               opcode;
	logic                 zero;
	logic                 carry;
	logic                 irLoad;
	logic                 operandLoad;
	logic                 accLoad;
	logic                 addrSelOperand;
	logic                 memWrite;
	logic                 pcIncrement;
	logic                 pcLoad;
	logic [addrWidth-1:0] pc;
	logic [addrWidth-1:0] memAddress;
	logic [dataWidth-1:0] operand;
	logic [dataWidth-1:0] memWriteData;
	logic [dataWidth-1:0] memReadData;
	logic [dataWidth-1:0] accumulator;

	assign outData = accumulator; // Valid while outStrobe is high

	controlFsm controlFsm_inst (
		.clk            (clk),
		.nRst           (nRst),
		.opcode         (opcode),
		.zero           (zero),
		.carry          (carry),
		.irLoad         (irLoad),
		.operandLoad    (operandLoad),
		.accLoad        (accLoad),
		.addrSelOperand (addrSelOperand),
		.memWrite       (memWrite),
		.pcIncrement    (pcIncrement),
		.pcLoad         (pcLoad),
		.outStrobe      (outStrobe),
		.halted         (halted)
	);

	progCounter progCounter_inst (
		.clk       (clk),
		.nRst      (nRst),
		.increment (pcIncrement),
		.load      (pcLoad),
		.loadValue (operand), // Jump target
		.pc        (pc)
	);

	dataPath dataPath_inst (
		.clk            (clk),
		.nRst           (nRst),
		.irLoad         (irLoad),
		.operandLoad    (operandLoad),
		.accLoad        (accLoad),
		.addrSelOperand (addrSelOperand),
		.pc             (pc),
		.memReadData    (memReadData),
		.inData         (inData),
		.opcode         (opcode),
		.operand        (operand),
		.zero           (zero),
		.carry          (carry),
		.memAddress     (memAddress),
		.memWriteData   (memWriteData),
		.accumulator    (accumulator)
	);

	upMemory upMemory_inst (
		.clk         (clk),
		.nRst        (nRst),
		.address     (memAddress),
		.writeData   (memWriteData),
		.writeEnable (memWrite),
		.readData    (memReadData),
		.testByte    (testByte)
	);

endmodule

`default_nettype wire

//--- src/dataPath.sv
`timescale 1ns/1ps
`default_nettype none

module dataPath (
	input  logic                            clk,
	input  logic                            nRst,
	input  logic                            irLoad,
	input  logic                            operandLoad,
	input  logic                            accLoad,
	input  logic                            addrSelOperand,
	input  logic [memMapPkg::addrWidth-1:0] pc,
	input  logic [isaPkg::dataWidth-1:0]    memReadData,
	input  logic [isaPkg::dataWidth-1:0]    inData,
	output isaPkg::opcodeT                  opcode,
	output logic [isaPkg::dataWidth-1:0]    operand,
	output logic                            zero,
	output logic                            carry,
	output logic [memMapPkg::addrWidth-1:0] memAddress,
	output logic [isaPkg::dataWidth-1:0]    memWriteData,
	output logic [isaPkg::dataWidth-1:0]    accumulator
);
	import isaPkg::*;

	opcodeT               ir;
	logic [dataWidth-1:0] acc;
	logic [dataWidth-1:0] accNext;
	logic                 carryNext;
	logic [flagCount-1:0] flags;
	logic [dataWidth:0]   sum;
	logic [dataWidth:0]   diff;

	always_ff @(posedge clk) begin
		if (irLoad) begin
			ir <= opcodeT'(memReadData);
		end
		if (operandLoad) begin
			operand <= memReadData;
		end
	end

	// Fetch bypass so the FSM sees the new opcode in the same cycle
	assign opcode     = irLoad ? opcodeT'(memReadData) : ir;
	assign memAddress = addrSelOperand ? operand : pc;

	assign sum  = {1'b0, acc} + {1'b0, memReadData};
	assign diff = {1'b0, acc} - {1'b0, memReadData}; // MSB is the borrow

	always_comb begin
		accNext   = acc;
		carryNext = flags[flagCarry]; // Loads keep the old carry
		case (ir)
			LDA: accNext = memReadData;
			LDI: accNext = operand;
			IN:  accNext = inData;
			ADD: begin
				accNext   = sum[dataWidth-1:0];
				carryNext = sum[dataWidth];
			end
			SUB: begin
				accNext   = diff[dataWidth-1:0];
				carryNext = diff[dataWidth];
			end
			AND: begin
				accNext   = acc & memReadData;
				carryNext = 1'b0;
			end
			OR: begin
				accNext   = acc | memReadData;
				carryNext = 1'b0;
			end
			XOR: begin
				accNext   = acc ^ memReadData;
				carryNext = 1'b0;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			acc   <= '0;
			flags <= '0;
		end else if (accLoad) begin
			acc              <= accNext;
			flags[flagZero]  <= (accNext == '0);
			flags[flagCarry] <= carryNext;
		end
	end

	assign zero         = flags[flagZero];
	assign carry        = flags[flagCarry];
	assign memWriteData = acc;
	assign accumulator  = acc;

endmodule

`default_nettype wire

//--- src/controlFsm.sv
`timescale 1ns/1ps
`default_nettype none

module controlFsm (
	input  logic           clk,
	input  logic           nRst,
	input  isaPkg::opcodeT opcode,
	input  logic           zero,
	input  logic           carry,
	output logic           irLoad,
	output logic           operandLoad,
	output logic           accLoad,
	output logic           addrSelOperand,
	output logic           memWrite,
	output logic           pcIncrement,
	output logic           pcLoad,
	output logic           outStrobe,
	output logic           halted
);
	import isaPkg::*;

	typedef enum logic [1:0] {
		FETCH,
		OPERAND,
		EXECUTE,
		HALT
	} fsmStateT;

	fsmStateT state;
	fsmStateT stateNext;
	logic     jumpTaken;

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			state <= FETCH;
		end else begin
			state <= stateNext;
		end
	end

	always_comb begin
		case (opcode)
			JMP:     jumpTaken = 1'b1;
			JZ:      jumpTaken = zero;
			JC:      jumpTaken = carry;
			default: jumpTaken = 1'b0;
		endcase
	end

	// In FETCH the opcode is the byte just read, so the length is known here
	always_comb begin
		stateNext = state;
		case (state)
			FETCH: begin
				stateNext = hasOperand(opcode) ? OPERAND : EXECUTE;
			end
			OPERAND: begin
				stateNext = EXECUTE;
			end
			EXECUTE: begin
				if (opcode == HLT || !isLegal(opcode)) begin
					stateNext = HALT;
				end else begin
					stateNext = FETCH;
				end
			end
			HALT: begin
				stateNext = HALT; // Only reset leaves
			end
			default: begin
				stateNext = FETCH;
			end
		endcase
	end

	always_comb begin
		irLoad         = 1'b0;
		operandLoad    = 1'b0;
		accLoad        = 1'b0;
		addrSelOperand = 1'b0;
		memWrite       = 1'b0;
		pcIncrement    = 1'b0;
		pcLoad         = 1'b0;
		outStrobe      = 1'b0;
		case (state)
			FETCH: begin
				irLoad      = 1'b1;
				pcIncrement = 1'b1;
			end
			OPERAND: begin
				operandLoad = 1'b1;
				pcIncrement = 1'b1;
			end
			EXECUTE: begin
				pcLoad    = jumpTaken; // Untaken jump leaves pc alone
				outStrobe = (opcode == OUT);
				memWrite  = (opcode == STA);
				case (opcode)
					LDA, ADD, SUB, AND, OR, XOR: begin
						accLoad        = 1'b1;
						addrSelOperand = 1'b1;
					end
					LDI, IN: begin
						accLoad = 1'b1;
					end
					STA: begin
						addrSelOperand = 1'b1;
					end
					default: begin
					end
				endcase
			end
			default: begin
			end
		endcase
	end

	assign halted = (state == HALT);

endmodule

`default_nettype wire

//--- src/progCounter.sv
`timescale 1ns/1ps
`default_nettype none

module progCounter (
	input  logic                            clk,
	input  logic                            nRst,
	input  logic                            increment,
	input  logic                            load,
	input  logic [memMapPkg::addrWidth-1:0] loadValue,
	output logic [memMapPkg::addrWidth-1:0] pc
);
	import memMapPkg::*;

	logic [addrWidth-1:0] pcNext;

	always_comb begin
		pcNext = pc;
		if (load) begin
			pcNext = loadValue; // Jump target wins
		end else if (increment) begin
			pcNext = pc + 1'b1; // Wraps past the top byte
		end
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			pc <= '0;
		end else begin
			pc <= pcNext;
		end
	end

endmodule

`default_nettype wire

//--- src/upMemory.sv
`timescale 1ns/1ps
`default_nettype none

module upMemory (
	input  logic                            clk,
	input  logic                            nRst,
	input  logic [memMapPkg::addrWidth-1:0] address,
	input  logic [isaPkg::dataWidth-1:0]    writeData,
	input  logic                            writeEnable,
	output logic [isaPkg::dataWidth-1:0]    readData,
	output logic [isaPkg::dataWidth-1:0]    testByte
);
	import isaPkg::*;
	import memMapPkg::*;

	logic [dataWidth-1:0] mem [memDepth];

	assign readData = mem[address]; // Asynchronous read
	assign testByte = mem[watchAddr];

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			for (int i = 0; i < memDepth; i++) begin
				mem[i] <= '0;
			end
			// Program bytes override the cleared low addresses
			for (int i = 0; i < progLength; i++) begin
				mem[i] <= resetImage[i];
			end
		end else if (writeEnable) begin
			mem[address] <= writeData;
		end
	end

endmodule

`default_nettype wire

//--- src/memMapPkg.sv
`default_nettype none

package memMapPkg;

	localparam int addrWidth  = 8;
	localparam int memDepth   = 256;
	localparam int watchAddr  = 127;
	localparam int progLength = 55;

	// Variable x lives at 80h and the pass counter at 81h
	// Constants start right after the HLT
	localparam logic [7:0] resetImage [progLength] = '{
		8'h50,        // 00 IN
		8'h11, 8'h80, // 01 STA x
		8'h21, 8'h30, // 03 SUB 80h
		8'h42, 8'h08, // 05 JC 08 skips the first OUT on a borrow
		8'h51,        // 07 OUT
		8'h10, 8'h80, // 08 LDA x
		8'h22, 8'h31, // 0A AND 03h
		8'h20, 8'h32, // 0C ADD 01h gives 1 to 4 passes
		8'h11, 8'h81, // 0E STA cnt
		8'h10, 8'h80, // 10 LDA x
		8'h20, 8'h33, // 12 ADD 37h
		8'h22, 8'h34, // 14 AND F5h
		8'h23, 8'h35, // 16 OR 08h
		8'h24, 8'h36, // 18 XOR 5Ah
		8'h11, 8'h80, // 1A STA x
		8'h51,        // 1C OUT
		8'h10, 8'h81, // 1D LDA cnt
		8'h21, 8'h32, // 1F SUB 01h
		8'h11, 8'h81, // 21 STA cnt
		8'h41, 8'h27, // 23 JZ 27
		8'h40, 8'h10, // 25 JMP 10
		8'h10, 8'h80, // 27 LDA x
		8'h11, 8'h7F, // 29 STA to the watch byte
		8'h51,        // 2B OUT
		8'h30, 8'h3C, // 2C LDI 3Ch
		8'h51,        // 2E OUT
		8'hFF,        // 2F HLT
		8'h80, 8'h03, 8'h01, 8'h37,
		8'hF5, 8'h08, 8'h5A
	};

endpackage

`default_nettype wire

//--- src/isaPkg.sv
`default_nettype none

package isaPkg;

	localparam int dataWidth = 8;

	typedef enum logic [7:0] {
		NOP = 8'h00,
		LDA = 8'h10, // Accumulator from memory
		STA = 8'h11,
		ADD = 8'h20,
		SUB = 8'h21, // Carry holds the borrow
		AND = 8'h22,
		OR  = 8'h23,
		XOR = 8'h24,
		LDI = 8'h30,
		JMP = 8'h40,
		JZ  = 8'h41,
		JC  = 8'h42,
		IN  = 8'h50,
		OUT = 8'h51,
		HLT = 8'hFF
	} opcodeT;

	// Flag register bit positions
	localparam int flagZero  = 0;
	localparam int flagCarry = 1;
	localparam int flagCount = 2;

	// Two-byte instructions sit in rows 1 to 4
	function automatic logic hasOperand(opcodeT op);
		return op[7:4] inside {[4'h1:4'h4]};
	endfunction

	function automatic logic isLegal(opcodeT op);
		case (op)
			NOP, LDA, STA, ADD, SUB, AND, OR, XOR, LDI, JMP, JZ, JC, IN, OUT, HLT: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

endpackage

`default_nettype wire
